//--- Makefile
SIM       = verilator
TOP       = tb_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
FAIL_MSG  = Regression failed
PASS_MSG  = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
hw/turbo_pkg.sv
hw/down_counter.sv
hw/turbo_timers.sv
hw/turbo_ctrl_fsm.sv
hw/settings_regs.sv
hw/buzzer_events.sv
hw/turbo_core_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- hw/buzzer_events.sv
////////////////////////////////////////////////////////////////////////////
// turbo activation tracking, cancel on buzzer and audio gating
// the audio sample is combinational from the buzzer input
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module buzzer_events (
  input  logic                clk_74a,
  input  logic                pll_core_locked,
  input  turbo_pkg::speed_t   turbo_speed,
  input  logic                buzzer,
  input  logic                cancel_on_event,
  input  logic                suppress_after_activation,
  input  logic                disable_sound,
  input  logic                suppress_active,
  output logic                suppress_arm,
  output logic                cancel_req,
  output turbo_pkg::sample_t  audio_sample
);

  logic speed_was_zero;
  logic speed_nonzero;

  assign speed_nonzero = (turbo_speed != '0);

  // speed is zero out of reset
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      speed_was_zero <= 1'b1;
    end else begin
      speed_was_zero <= !speed_nonzero;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // activation and cancel

  // turbo newly switched on
  assign suppress_arm = suppress_after_activation && speed_was_zero && speed_nonzero;

  // drops by itself once the speed has gone back to zero
  assign cancel_req = cancel_on_event && buzzer && speed_nonzero
                      && !suppress_active && !suppress_arm;

  ////////////////////////////////////////////////////////////////////////////
  // audio

  always_comb begin
    if (!disable_sound && (turbo_speed < turbo_pkg::AUDIO_FAST_SPEED)) begin
      audio_sample = {2'b00, {13{buzzer}}};
    end else begin
      audio_sample = '0;
    end
  end

endmodule

//--- hw/down_counter.sv
////////////////////////////////////////////////////////////////////////////
// loadable down counter that stops at zero
// load and clear must not be requested in the same cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module down_counter #(
  parameter type count_t = logic [7:0]
) (
  input  logic   clk_74a,
  input  logic   pll_core_locked,
  input  logic   load,
  input  count_t load_value,
  input  logic   dec_en,
  input  logic   clear,
  output logic   busy
);

  count_t count;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (dec_en && busy) begin
      count <= count - count_t'(1);
    end
  end

  assign busy = (count != '0);

  // the owner of the timer never restarts and cancels it together
  load_clear_excl: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked) !(load && clear)
  );

endmodule

//--- hw/settings_regs.sv
////////////////////////////////////////////////////////////////////////////
// bridge settings registers, synchronous to clk_74a
// bridge_wr is a single-cycle strobe, reads are a combinational mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module settings_regs (
  input  logic               clk_74a,
  input  logic               pll_core_locked,
  input  turbo_pkg::addr_t   bridge_addr,
  input  logic               bridge_wr,
  input  turbo_pkg::data_t   bridge_wr_data,
  input  turbo_pkg::speed_t  turbo_speed,
  output turbo_pkg::data_t   bridge_rd_data,
  output logic               turbo_load,
  output turbo_pkg::speed_t  turbo_load_value,
  output logic               reset_start,
  output logic               disable_sound,
  output logic               cancel_on_event,
  output logic               suppress_after_activation,
  output logic               show_pixel_dividers,
  output logic               show_pixel_grid
);

  turbo_pkg::lcd_mode_t lcd_mode;

  // strobes take effect on the write edge itself
  assign turbo_load  = bridge_wr && (bridge_addr == turbo_pkg::ADDR_TURBO);
  assign reset_start = bridge_wr && (bridge_addr == turbo_pkg::ADDR_RESET);

  // large words saturate so the FSM clamps them to the top speed
  assign turbo_load_value = (bridge_wr_data[31:3] != '0) ? '1 : bridge_wr_data[2:0];

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      disable_sound             <= 1'b0;
      cancel_on_event           <= 1'b0;
      suppress_after_activation <= 1'b0;
      lcd_mode                  <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        turbo_pkg::ADDR_SOUND:    disable_sound <= bridge_wr_data[0];
        turbo_pkg::ADDR_CANCEL:   cancel_on_event <= bridge_wr_data[0];
        turbo_pkg::ADDR_SUPPRESS: suppress_after_activation <= bridge_wr_data[0];
        turbo_pkg::ADDR_LCD:      lcd_mode <= bridge_wr_data[1:0];
        default: ;
      endcase
    end
  end

  // only the turbo speed reads back
  always_comb begin
    if (bridge_addr == turbo_pkg::ADDR_TURBO) begin
      bridge_rd_data = turbo_pkg::data_t'(turbo_speed);
    end else begin
      bridge_rd_data = '0;
    end
  end

  // lcd mode 1 draws dividers, mode 2 adds the background grid
  assign show_pixel_dividers = (lcd_mode != '0);
  assign show_pixel_grid     = (lcd_mode == 2'd2);

endmodule

//--- hw/turbo_core_top.sv
////////////////////////////////////////////////////////////////////////////
// turbo and settings control, single clock domain on clk_74a
// buzzer arrives as a level, audio leaves as a parallel sample
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module turbo_core_top (
  input  logic                clk_74a,
  input  logic                pll_core_locked,
  input  turbo_pkg::addr_t    bridge_addr,
  input  logic                bridge_wr,
  input  turbo_pkg::data_t    bridge_wr_data,
  input  logic                key_l,
  input  logic                key_r,
  input  logic                buzzer,
  output turbo_pkg::data_t    bridge_rd_data,
  output turbo_pkg::speed_t   turbo_speed,
  output logic                show_turbo_ui,
  output logic                core_reset,
  output turbo_pkg::sample_t  audio_sample,
  output logic                show_pixel_dividers,
  output logic                show_pixel_grid
);

  logic              turbo_load;
  turbo_pkg::speed_t turbo_load_value;
  logic              reset_start;
  logic              disable_sound;
  logic              cancel_on_event;
  logic              suppress_after_activation;
  logic              button_arm;
  logic              button_clear;
  logic              ui_arm;
  logic              button_busy;
  logic              suppress_arm;
  logic              suppress_active;
  logic              cancel_req;

  settings_regs u_settings (
    .clk_74a                   (clk_74a),
    .pll_core_locked           (pll_core_locked),
    .bridge_addr               (bridge_addr),
    .bridge_wr                 (bridge_wr),
    .bridge_wr_data            (bridge_wr_data),
    .turbo_speed               (turbo_speed),
    .bridge_rd_data            (bridge_rd_data),
    .turbo_load                (turbo_load),
    .turbo_load_value          (turbo_load_value),
    .reset_start               (reset_start),
    .disable_sound             (disable_sound),
    .cancel_on_event           (cancel_on_event),
    .suppress_after_activation (suppress_after_activation),
    .show_pixel_dividers       (show_pixel_dividers),
    .show_pixel_grid           (show_pixel_grid)
  );

  turbo_ctrl_fsm u_fsm (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .key_l            (key_l),
    .key_r            (key_r),
    .turbo_load       (turbo_load),
    .turbo_load_value (turbo_load_value),
    .cancel_req       (cancel_req),
    .button_busy      (button_busy),
    .turbo_speed      (turbo_speed),
    .button_arm       (button_arm),
    .button_clear     (button_clear),
    .ui_arm           (ui_arm)
  );

  // indicator is the UI timer itself
  turbo_timers u_timers (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .button_arm      (button_arm),
    .button_clear    (button_clear),
    .ui_arm          (ui_arm),
    .reset_start     (reset_start),
    .suppress_arm    (suppress_arm),
    .button_busy     (button_busy),
    .ui_active       (show_turbo_ui),
    .core_reset      (core_reset),
    .suppress_active (suppress_active),
    .core_tick       ()
  );

  buzzer_events u_buzzer (
    .clk_74a                   (clk_74a),
    .pll_core_locked           (pll_core_locked),
    .turbo_speed               (turbo_speed),
    .buzzer                    (buzzer),
    .cancel_on_event           (cancel_on_event),
    .suppress_after_activation (suppress_after_activation),
    .disable_sound             (disable_sound),
    .suppress_active           (suppress_active),
    .suppress_arm              (suppress_arm),
    .cancel_req                (cancel_req),
    .audio_sample              (audio_sample)
  );

endmodule

//--- hw/turbo_ctrl_fsm.sv
////////////////////////////////////////////////////////////////////////////
// turbo speed owner: trigger keys, bridge loads and buzzer cancels
// priority is bridge load, then cancel, then keys
// the left key wins when both triggers are pressed
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module turbo_ctrl_fsm (
  input  logic              clk_74a,
  input  logic              pll_core_locked,
  input  logic              key_l,
  input  logic              key_r,
  input  logic              turbo_load,
  input  turbo_pkg::speed_t turbo_load_value,
  input  logic              cancel_req,
  input  logic              button_busy,
  output turbo_pkg::speed_t turbo_speed,
  output logic              button_arm,
  output logic              button_clear,
  output logic              ui_arm
);

  typedef enum logic {
    st_idle,
    st_held
  } state_t;

  state_t            state;
  state_t            next_state;
  turbo_pkg::speed_t next_speed;
  logic              key_any;
  logic              release_keys;
  logic              key_step;

  assign key_any      = key_l || key_r;
  assign release_keys = (state == st_held) && !key_any;
  // first press acts at once, a held key waits for the repeat timer
  assign key_step     = key_any && ((state == st_idle) || !button_busy);

  always_comb begin
    next_state   = state;
    next_speed   = turbo_speed;
    button_arm   = 1'b0;
    button_clear = 1'b0;
    ui_arm       = 1'b0;

    if (turbo_load) begin
      // direct set, the indicator is left alone
      if (turbo_load_value > turbo_pkg::TURBO_MAX) begin
        next_speed = turbo_pkg::TURBO_MAX;
      end else begin
        next_speed = turbo_load_value;
      end
    end else if (cancel_req && (turbo_speed != '0)) begin
      next_speed = '0;
      ui_arm     = 1'b1;
      button_arm = !release_keys;
      if (key_any) begin
        next_state = st_held;
      end
    end else if (key_step) begin
      ui_arm     = 1'b1;
      button_arm = 1'b1;
      next_state = st_held;
      if (key_l) begin
        if (turbo_speed != '0) begin
          next_speed = turbo_speed - turbo_pkg::speed_t'(1);
        end
      end else if (turbo_speed < turbo_pkg::TURBO_MAX) begin
        next_speed = turbo_speed + turbo_pkg::speed_t'(1);
      end
    end

    if (release_keys) begin
      button_clear = 1'b1;
      next_state   = st_idle;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state       <= st_idle;
      turbo_speed <= '0;
    end else begin
      state       <= next_state;
      turbo_speed <= next_speed;
    end
  end

  speed_in_range: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked) turbo_speed <= turbo_pkg::TURBO_MAX
  );

endmodule

//--- hw/turbo_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, register map and timer lengths for the turbo control
// delays are scaled for short simulation and are not real-time values
// every count type is sized from its own delay
////////////////////////////////////////////////////////////////////////////

package turbo_pkg;

  // bridge bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // payloads
  typedef logic [2:0]  speed_t;
  typedef logic [14:0] sample_t;
  typedef logic [1:0]  lcd_mode_t;

  localparam speed_t TURBO_MAX        = 3'd4;
  // mute the buzzer at this speed and above
  localparam speed_t AUDIO_FAST_SPEED = 3'd2;

  // register map
  localparam addr_t ADDR_RESET    = 32'h0000_0000;
  localparam addr_t ADDR_SOUND    = 32'h0000_0010;
  localparam addr_t ADDR_TURBO    = 32'h0000_0100;
  localparam addr_t ADDR_CANCEL   = 32'h0000_0104;
  localparam addr_t ADDR_SUPPRESS = 32'h0000_0108;
  localparam addr_t ADDR_LCD      = 32'h0000_0200;

  // cycle timers, in clk_74a cycles
  localparam int BUTTON_DELAY = 16;
  localparam int UI_DELAY     = 64;
  localparam int RESET_DELAY  = 32;

  // core time
  localparam int CORE_TICK_DIV  = 4;
  localparam int SUPPRESS_TICKS = 10;

  typedef logic [$clog2(BUTTON_DELAY+1)-1:0]   button_cnt_t;
  typedef logic [$clog2(UI_DELAY+1)-1:0]       ui_cnt_t;
  typedef logic [$clog2(RESET_DELAY+1)-1:0]    reset_cnt_t;
  typedef logic [$clog2(SUPPRESS_TICKS+1)-1:0] suppress_cnt_t;
  typedef logic [$clog2(CORE_TICK_DIV)-1:0]    tick_cnt_t;

endpackage

//--- hw/turbo_timers.sv
////////////////////////////////////////////////////////////////////////////
// button repeat, indicator, core reset and suppression timers
// the suppression window counts core ticks, the others count clk_74a
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module turbo_timers (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic button_arm,
  input  logic button_clear,
  input  logic ui_arm,
  input  logic reset_start,
  input  logic suppress_arm,
  output logic button_busy,
  output logic ui_active,
  output logic core_reset,
  output logic suppress_active,
  output logic core_tick
);

  turbo_pkg::tick_cnt_t tick_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // core tick divider

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      tick_cnt <= '0;
    end else if (core_tick) begin
      tick_cnt <= turbo_pkg::tick_cnt_t'(turbo_pkg::CORE_TICK_DIV - 1);
    end else begin
      tick_cnt <= tick_cnt - turbo_pkg::tick_cnt_t'(1);
    end
  end

  assign core_tick = (tick_cnt == '0);

  ////////////////////////////////////////////////////////////////////////////
  // timers

  // repeat delay while a trigger is held
  down_counter #(.count_t(turbo_pkg::button_cnt_t)) u_button (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .load            (button_arm),
    .load_value      (turbo_pkg::button_cnt_t'(turbo_pkg::BUTTON_DELAY)),
    .dec_en          (1'b1),
    .clear           (button_clear),
    .busy            (button_busy)
  );

  down_counter #(.count_t(turbo_pkg::ui_cnt_t)) u_ui (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .load            (ui_arm),
    .load_value      (turbo_pkg::ui_cnt_t'(turbo_pkg::UI_DELAY)),
    .dec_en          (1'b1),
    .clear           (1'b0),
    .busy            (ui_active)
  );

  down_counter #(.count_t(turbo_pkg::reset_cnt_t)) u_reset (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .load            (reset_start),
    .load_value      (turbo_pkg::reset_cnt_t'(turbo_pkg::RESET_DELAY)),
    .dec_en          (1'b1),
    .clear           (1'b0),
    .busy            (core_reset)
  );

  // counted in core time, not in clocks
  down_counter #(.count_t(turbo_pkg::suppress_cnt_t)) u_suppress (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .load            (suppress_arm),
    .load_value      (turbo_pkg::suppress_cnt_t'(turbo_pkg::SUPPRESS_TICKS)),
    .dec_en          (core_tick),
    .clear           (1'b0),
    .busy            (suppress_active)
  );

  core_tick_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked) core_tick |=> !core_tick
  );

endmodule

//--- testbench/tb_checker.sv
////////////////////////////////////////////////////////////////////////////
// reference model and comparisons for the turbo control testbench
// the model follows bridge writes and key steps as the stimulus reports them
// audio gating is checked on every falling edge while enabled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_checker (
  input  logic               clk_74a,
  input  logic               pll_core_locked,
  input  logic               buzzer,
  input  turbo_pkg::speed_t  turbo_speed,
  input  turbo_pkg::sample_t audio_sample
);

  // model state
  int unsigned model_speed;
  logic        model_mute;
  logic [1:0]  model_lcd;
  logic        audio_check_en;

  // bookkeeping
  string       test_name;
  int          test_errors;
  int          error_count;
  int          tests_passed;
  int          tests_failed;

  initial begin
    model_speed    = 0;
    model_mute     = 1'b0;
    model_lcd      = 2'd0;
    audio_check_en = 1'b0;
    test_name      = "none";
    test_errors    = 0;
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
  end

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      test_errors++;
      error_count++;
      $display("[FAIL] %s/%s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  // problems that are not a wrong value
  task automatic report_error(input string what);
    test_errors++;
    error_count++;
    $display("ERROR in %s: %s", test_name, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model updates

  task automatic model_write(input turbo_pkg::addr_t addr, input turbo_pkg::data_t data);
    if (addr == turbo_pkg::ADDR_TURBO) begin
      model_speed = (data > 32'd4) ? 4 : int'(data);
    end else if (addr == turbo_pkg::ADDR_SOUND) begin
      model_mute = data[0];
    end else if (addr == turbo_pkg::ADDR_LCD) begin
      model_lcd = data[1:0];
    end
  endtask

  // left key lowers and wins, right key raises, both saturate
  task automatic model_key(input logic l, input logic r);
    if (l) begin
      if (model_speed > 0) model_speed--;
    end else if (r) begin
      if (model_speed < 4) model_speed++;
    end
  endtask

  task automatic check_speed(input string what);
    compare(what, model_speed, 32'(turbo_speed));
  endtask

  function automatic logic [31:0] expected_audio(input logic buz, input int unsigned spd);
    if (!model_mute && spd < 2 && buz) begin
      return 32'h1fff;
    end
    return 32'h0;
  endfunction

  always @(negedge clk_74a) begin
    if (pll_core_locked && audio_check_en) begin
      compare("audio", expected_audio(buzzer, model_speed), 32'(audio_sample));
    end
  end

  task automatic summarize();
    $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             error_count);
  endtask

endmodule

//--- testbench/tb_top.sv
////////////////////////////////////////////////////////////////////////////
// testbench for turbo_core_top, one clock at 100 ns
// inputs change 10 ns after the rising edge, random stimulus is seeded
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_top;

  logic               clk_74a;
  logic               pll_core_locked;
  turbo_pkg::addr_t   bridge_addr;
  logic               bridge_wr;
  turbo_pkg::data_t   bridge_wr_data;
  logic               key_l;
  logic               key_r;
  logic               buzzer;
  turbo_pkg::data_t   bridge_rd_data;
  turbo_pkg::speed_t  turbo_speed;
  logic               show_turbo_ui;
  logic               core_reset;
  turbo_pkg::sample_t audio_sample;
  logic               show_pixel_dividers;
  logic               show_pixel_grid;

  turbo_core_top UUT (.*);

  tb_checker u_chk (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .buzzer          (buzzer),
    .turbo_speed     (turbo_speed),
    .audio_sample    (audio_sample)
  );

  always #50 clk_74a = ~clk_74a;

  task automatic next_cycle();
    @(posedge clk_74a);
    #10;
  endtask

  task automatic bus_write(input turbo_pkg::addr_t addr, input turbo_pkg::data_t data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr      = 1'b0;
    u_chk.model_write(addr, data);
  endtask

  // one step, held for fewer cycles than the repeat delay
  task automatic press_keys(input logic l, input logic r, input int hold);
    key_l = l;
    key_r = r;
    next_cycle();
    u_chk.model_key(l, r);
    u_chk.check_speed("step");
    repeat (hold - 1) next_cycle();
    key_l = 1'b0;
    key_r = 1'b0;
    next_cycle();
    next_cycle();
  endtask

  initial begin
    int n;
    turbo_pkg::addr_t a;
    turbo_pkg::data_t d;

    void'($urandom(32'h693f));
    clk_74a         = 1'b0;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    key_l           = 1'b0;
    key_r           = 1'b0;
    buzzer          = 1'b0;
    repeat (3) @(posedge clk_74a);
    #10;
    pll_core_locked = 1'b1;
    next_cycle();
    u_chk.audio_check_en = 1'b1;

    u_chk.begin_test("bridge registers");
    for (int i = 0; i < 24; i++) begin
      case ($urandom % 3)
        0: a = turbo_pkg::ADDR_TURBO;
        1: a = turbo_pkg::ADDR_LCD;
        default: a = turbo_pkg::ADDR_SOUND;
      endcase
      d = ($urandom % 4 == 0) ? $urandom : $urandom % 8;
      bus_write(a, d);
      bridge_addr = turbo_pkg::ADDR_TURBO;
      #1;
      u_chk.compare("readback", u_chk.model_speed, bridge_rd_data);
      bridge_addr = turbo_pkg::ADDR_LCD;
      #1;
      u_chk.compare("other address", 0, bridge_rd_data);
      u_chk.compare("dividers", 32'(u_chk.model_lcd != 0), 32'(show_pixel_dividers));
      u_chk.compare("grid", 32'(u_chk.model_lcd == 2), 32'(show_pixel_grid));
    end
    bus_write(turbo_pkg::ADDR_SOUND, 0);
    u_chk.end_test();

    u_chk.begin_test("key steps");
    for (int i = 0; i < 30; i++) begin
      press_keys(1'($urandom), 1'($urandom % 4 != 0), 1 + ($urandom % 8));
    end
    press_keys(1'b1, 1'b1, 3);
    u_chk.end_test();

    u_chk.begin_test("turbo indicator");
    // let the indicator from the key steps run out first
    n = 0;
    while (show_turbo_ui && n <= turbo_pkg::UI_DELAY + 2) begin
      next_cycle();
      n++;
    end
    u_chk.compare("ui off before step", 0, 32'(show_turbo_ui));
    key_r = 1'b1;
    next_cycle();
    u_chk.model_key(1'b0, 1'b1);
    u_chk.check_speed("ui step");
    u_chk.compare("ui on", 1, 32'(show_turbo_ui));
    key_r = 1'b0;
    n = 1;
    while (show_turbo_ui && n <= turbo_pkg::UI_DELAY + 2) begin
      next_cycle();
      n++;
    end
    if (show_turbo_ui) u_chk.report_error("indicator did not turn off in time");
    u_chk.end_test();

    u_chk.begin_test("core reset");
    bus_write(turbo_pkg::ADDR_RESET, 1);
    u_chk.compare("reset on", 1, 32'(core_reset));
    n = 1;
    while (core_reset && n <= turbo_pkg::RESET_DELAY + 2) begin
      next_cycle();
      n++;
    end
    if (core_reset) u_chk.report_error("core reset did not end in time");
    u_chk.end_test();

    u_chk.begin_test("buzzer cancel");
    bus_write(turbo_pkg::ADDR_CANCEL, 1);
    bus_write(turbo_pkg::ADDR_SUPPRESS, 0);
    bus_write(turbo_pkg::ADDR_TURBO, 3);
    next_cycle();
    buzzer = 1'b1;
    next_cycle();
    buzzer = 1'b0;
    n = 0;
    while (turbo_speed != 0 && n < 3) begin
      next_cycle();
      n++;
    end
    u_chk.model_speed = 0;
    u_chk.check_speed("cancel");
    // activation from zero opens the suppression window
    bus_write(turbo_pkg::ADDR_SUPPRESS, 1);
    bus_write(turbo_pkg::ADDR_TURBO, 2);
    buzzer = 1'b1;
    next_cycle();
    buzzer = 1'b0;
    repeat (3) next_cycle();
    u_chk.check_speed("suppressed");
    bus_write(turbo_pkg::ADDR_CANCEL, 0);
    u_chk.end_test();

    u_chk.begin_test("audio gating");
    for (int i = 0; i < 60; i++) begin
      buzzer = 1'($urandom);
      case ($urandom % 4)
        0: bus_write(turbo_pkg::ADDR_SOUND, $urandom % 2);
        1: bus_write(turbo_pkg::ADDR_TURBO, $urandom % 5);
        default: next_cycle();
      endcase
      u_chk.check_speed("speed");
    end
    buzzer = 1'b0;
    next_cycle();
    u_chk.end_test();

    u_chk.summarize();
    if (u_chk.error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // stop a run that never reaches its end
  initial begin
    #2_000_000;
    $display("timeout: the test sequence did not finish");
    $display("Regression failed");
    $finish;
  end

endmodule
